// ==== dispatch_stage.f ====
+incdir+tests
source/dispatch_pkg.sv
source/register_file.sv
source/rename_buffer.sv
source/reservation_station.sv
source/dispatch_stage.sv
tests/tb_dispatch_stage.sv

// ==== Makefile ====
# Verilator flow for the dispatch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_dispatch_stage
FILELIST  ?= dispatch_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/dispatch_checks.svh ====
`ifndef DISPATCH_CHECKS_SVH
`define DISPATCH_CHECKS_SVH

// ============================================================================
// Reference model
// ============================================================================
// Functional unit result selected by op
function automatic logic [DATA_WIDTH-1:0] alu_ref(logic [3:0] op,
                                                   logic [DATA_WIDTH-1:0] a,
                                                   logic [DATA_WIDTH-1:0] b);
    int sel;
    sel = int'(op) % 6;
    case (sel)
        0:       return a + b;
        1:       return a ^ b;
        2:       return a | b;
        3:       return a & b;
        4:       return a - b;
        default: return a << b[4:0];
    endcase
endfunction

// Operand value in program order at dispatch
function automatic logic [DATA_WIDTH-1:0] expected_operand(logic from_imm, arch_addr_t idx,
                                                            logic [DATA_WIDTH-1:0] imm);
    if (from_imm) begin
        return imm;
    end
    if (idx == '0) begin
        return '0;                              // x0
    end
    if (pending[idx]) begin
        return pend_val[idx];                   // Newest producer still in flight
    end
    return shadow[idx];
endfunction

// ============================================================================
// Compare tasks
// ============================================================================
task automatic check_exec(int lane, exec_t expected, exec_t actual);
    if (actual !== expected) begin
        stop_run($sformatf("error at %0t: lane %0d exec op %h rd %0d a %h b %h, expected %s",
            $time, lane, actual.op, actual.rd, actual.operand_a, actual.operand_b,
            $sformatf("op %h rd %0d a %h b %h",
                expected.op, expected.rd, expected.operand_a, expected.operand_b)));
    end
endtask

task automatic check_commit(int port, commit_t expected, commit_t actual);
    if (actual !== expected) begin
        stop_run($sformatf("error at %0t: commit %0d valid %b x%0d %h, expected valid %b x%0d %h",
            $time, port, actual.valid, actual.addr, actual.data,
            expected.valid, expected.addr, expected.data));
    end
endtask

`endif

// ==== tests/tb_dispatch_stage.sv ====
`timescale 1ns/1ps

module tb_dispatch_stage
    import dispatch_pkg::*;
();

    localparam int TOTAL_INSTR = 420;                   // Sum of all phases
    localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR + 100;
    localparam int MAX_ID      = 512;

    logic                    clk;
    logic                    rst;
    issue_t [NUM_LANES-1:0]  issue;
    logic [NUM_LANES-1:0]    issue_valid;
    logic [NUM_LANES-1:0]    issue_ready;
    exec_t [NUM_LANES-1:0]   exec;
    logic [NUM_LANES-1:0]    exec_valid;
    logic [NUM_LANES-1:0]    exec_ready;
    cdb_t [NUM_LANES-1:0]    cdb;
    commit_t [NUM_LANES-1:0] commit;

    // Issue-stage model state
    logic [DATA_WIDTH-1:0] shadow   [NUM_ARCH_REGS];    // From observed commits
    logic [DATA_WIDTH-1:0] pend_val [NUM_ARCH_REGS];
    logic                  pending  [NUM_ARCH_REGS];
    int                    latest   [NUM_ARCH_REGS];    // Id of newest writer
    arch_addr_t            id_rd      [MAX_ID];
    logic                  id_writes  [MAX_ID];
    logic [DATA_WIDTH-1:0] id_result  [MAX_ID];
    int                    id_lane    [MAX_ID];
    issue_t                held       [NUM_LANES];
    logic                  have_held  [NUM_LANES];
    exec_t                 exp_q      [NUM_LANES][$];   // Expected exec in issue order
    int                    exp_id     [NUM_LANES][$];
    int                    bcast_q    [NUM_LANES][$];   // Writers not yet on the CDB

    // Functional-unit model state
    logic    fu_busy     [NUM_LANES];
    int      fu_count    [NUM_LANES];
    int      fu_id       [NUM_LANES];
    logic    done_now    [NUM_LANES];
    commit_t exp_commit  [NUM_LANES];
    int      exp_commit_id [NUM_LANES];
    logic    stalled     [NUM_LANES];
    exec_t   last_exec   [NUM_LANES];

    int generated;
    int issued;
    int target;
    int cycles;
    int imm_pct;
    int ready_pct;
    int rd_max;

    `include "dispatch_checks.svh"

    dispatch_stage u_dispatch_stage (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .exec        (exec),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .cdb         (cdb),
        .commit      (commit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                              // 100 ns period

    task automatic stop_run(string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            stop_run($sformatf("Timeout, run not finished after %0d cycles", CYCLE_LIMIT));
        end
    end

    // ========================================================================
    // Issue-stage helpers
    // ========================================================================
    function automatic issue_t make_instr();
        issue_t ins;
        ins.ctrl.writes_rd = ($urandom % 100) < 85;
        ins.ctrl.use_imm   = ($urandom % 100) < imm_pct;
        ins.ctrl.op        = 4'($urandom);
        ins.rs1.in_buffer  = 1'b0;
        ins.rs1.index      = 5'($urandom % (rd_max + 1));
        ins.rs2.in_buffer  = 1'b0;
        ins.rs2.index      = 5'($urandom % (rd_max + 1));
        ins.rd             = 5'($urandom % (rd_max + 1));   // x0 writes too
        ins.imm            = $urandom;
        return ins;
    endfunction

    // Waiter wakes on the next broadcast of its slot so the producer must be first
    function automatic logic source_safe(arch_addr_t idx);
        int lane;
        if (idx == '0 || !pending[idx]) begin
            return 1'b1;
        end
        lane = id_lane[latest[idx]];
        for (int i = 1; i < bcast_q[lane].size(); i++) begin
            if (bcast_q[lane][i] == latest[idx]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic can_issue(int k, issue_t ins);
        if (!source_safe(ins.rs1.index)) begin
            return 1'b0;
        end
        if (!ins.ctrl.use_imm && !source_safe(ins.rs2.index)) begin
            return 1'b0;
        end
        if (ins.ctrl.writes_rd && ins.rd != '0) begin
            for (int i = 0; i < bcast_q[k].size(); i++) begin
                if (id_rd[bcast_q[k][i]] == ins.rd) begin
                    return 1'b0;                    // Same tag and rd already in flight
                end
            end
        end
        return 1'b1;
    endfunction

    function automatic logic idle();
        for (int k = 0; k < NUM_LANES; k++) begin
            if (have_held[k] || fu_busy[k] || exp_q[k].size() != 0 ||
                bcast_q[k].size() != 0 || exp_commit[k].valid || exec_valid[k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ========================================================================
    // Per-cycle drive and sample
    // ========================================================================
    task automatic drive_inputs();
        @(posedge clk);
        #5;
        for (int k = 0; k < NUM_LANES; k++) begin
            done_now[k] = 1'b0;
            cdb[k]      = '0;
            if (fu_busy[k]) begin
                fu_count[k]--;
                if (fu_count[k] == 0) begin
                    done_now[k] = 1'b1;
                    if (id_writes[fu_id[k]]) begin          // Slot k is lane k
                        cdb[k].valid = 1'b1;
                        cdb[k].rd    = id_rd[fu_id[k]];
                        cdb[k].data  = id_result[fu_id[k]];
                    end
                end
            end
            exec_ready[k] = !fu_busy[k] && (($urandom % 100) < ready_pct);
            if (!have_held[k] && generated < target) begin
                held[k]      = make_instr();
                have_held[k] = 1'b1;
                generated++;
            end
            issue_valid[k]        = have_held[k] && can_issue(k, held[k]);
            issue[k]              = held[k];
            issue[k].rs1.in_buffer = pending[held[k].rs1.index];
            issue[k].rs2.in_buffer = pending[held[k].rs2.index];
        end
    endtask

    task automatic sample_outputs();
        logic [NUM_LANES-1:0]     acc_v;
        logic [NUM_ARCH_REGS-1:0] alloc_set;
        int                       id_l [NUM_LANES];
        int                       id;
        exec_t                    e;
        @(negedge clk);
        for (int k = 0; k < NUM_LANES; k++) begin
            check_commit(k, exp_commit[k], commit[k]);
            if (commit[k].valid) begin
                shadow[commit[k].addr] = commit[k].data;
                if (latest[commit[k].addr] == exp_commit_id[k]) begin
                    pending[commit[k].addr] = 1'b0;
                end
            end
        end
        // Back-pressure
        for (int k = 0; k < NUM_LANES; k++) begin
            if (stalled[k]) begin
                if (!exec_valid[k]) begin
                    stop_run($sformatf("Lane %0d dropped exec_valid while stalled", k));
                end
                check_exec(k, last_exec[k], exec[k]);
            end
            if (exec_valid[k] && !exec_ready[k] && issue_ready[k]) begin
                stop_run($sformatf("error at %0t: lane %0d issue_ready high while stalled",
                    $time, k));
            end
            stalled[k]   = exec_valid[k] && !exec_ready[k];
            last_exec[k] = exec[k];
        end
        // Exec transfers into the FU model
        for (int k = 0; k < NUM_LANES; k++) begin
            if (exec_valid[k] && exec_ready[k]) begin
                if (exp_q[k].size() == 0) begin
                    stop_run($sformatf("Lane %0d issued an instruction never dispatched", k));
                end
                check_exec(k, exp_q[k].pop_front(), exec[k]);
                fu_id[k]    = exp_id[k].pop_front();
                fu_busy[k]  = 1'b1;
                fu_count[k] = 1 + int'($urandom % 4);
            end
        end
        acc_v     = '0;
        alloc_set = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            acc_v[k] = issue_valid[k] && issue_ready[k];
            if (acc_v[k] && issue[k].ctrl.writes_rd && issue[k].rd != '0) begin
                alloc_set[issue[k].rd] = 1'b1;
            end
        end
        // Broadcasts land only on the newest writer and lose to alloc
        for (int k = 0; k < NUM_LANES; k++) begin
            exp_commit[k] = '0;
            if (done_now[k]) begin
                fu_busy[k] = 1'b0;
                if (id_writes[fu_id[k]]) begin
                    id = bcast_q[k].pop_front();
                    if (id_rd[id] != '0 && latest[id_rd[id]] == id && !alloc_set[id_rd[id]]) begin
                        exp_commit[k].valid = 1'b1;
                        exp_commit[k].addr  = id_rd[id];
                        exp_commit[k].data  = id_result[id];
                        exp_commit_id[k]    = id;
                    end
                end
            end
        end
        // All lanes read state from before this edge
        for (int k = 0; k < NUM_LANES; k++) begin
            if (acc_v[k]) begin
                id           = issued;
                id_l[k]      = id;
                issued++;
                e.op         = issue[k].ctrl.op;
                e.rd         = issue[k].rd;
                e.operand_a  = expected_operand(1'b0, issue[k].rs1.index, issue[k].imm);
                e.operand_b  = expected_operand(issue[k].ctrl.use_imm, issue[k].rs2.index,
                                                issue[k].imm);
                id_rd[id]     = issue[k].rd;
                id_writes[id] = issue[k].ctrl.writes_rd;
                id_result[id] = alu_ref(e.op, e.operand_a, e.operand_b);
                id_lane[id]   = k;
                exp_q[k].push_back(e);
                exp_id[k].push_back(id);
                have_held[k] = 1'b0;
            end
        end
        for (int k = 0; k < NUM_LANES; k++) begin      // Higher lane last so it wins
            if (acc_v[k] && issue[k].ctrl.writes_rd) begin
                bcast_q[k].push_back(id_l[k]);
                if (issue[k].rd != '0) begin
                    latest[issue[k].rd]   = id_l[k];
                    pending[issue[k].rd]  = 1'b1;
                    pend_val[issue[k].rd] = id_result[id_l[k]];
                end
            end
        end
    endtask

    task automatic run_phase(int count, int imm, int ready, int rmax);
        imm_pct   = imm;
        ready_pct = ready;
        rd_max    = rmax;
        target    = target + count;
        while (issued < target) begin
            drive_inputs();
            sample_outputs();
        end
    endtask

    // ========================================================================
    // Scenarios
    // ========================================================================
    initial begin
        void'($urandom(97));
        rst         = 1'b1;
        issue       = '0;
        issue_valid = '0;
        exec_ready  = '0;
        cdb         = '0;
        generated   = 0;
        issued      = 0;
        target      = 0;
        cycles      = 0;
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            shadow[r]   = '0;
            pend_val[r] = '0;
            pending[r]  = 1'b0;
            latest[r]   = -1;
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            held[k]          = '0;
            have_held[k]     = 1'b0;
            fu_busy[k]       = 1'b0;
            fu_count[k]      = 0;
            done_now[k]      = 1'b0;
            exp_commit[k]    = '0;
            exp_commit_id[k] = -1;
            stalled[k]       = 1'b0;
        end
        repeat (8) @(posedge clk);
        #5 rst = 1'b0;
        @(negedge clk);
        if (issue_ready !== '1 || exec_valid !== '0) begin
            stop_run($sformatf("error at %0t: handshakes wrong after reset", $time));
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            check_commit(k, '0, commit[k]);
        end
        run_phase(40, 90, 90, 31);      // Immediates and x0 reads
        run_phase(40, 20, 80, 3);       // Dependencies, shared rd and x0 writes
        run_phase(40, 30, 15, 7);       // Back-pressure
        run_phase(300, 30, 60, 15);     // Random mix
        ready_pct = 80;
        while (!idle()) begin
            drive_inputs();
            sample_outputs();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== source/dispatch_stage.sv ====
`timescale 1ns/1ps

module dispatch_stage
    import dispatch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  issue_t [NUM_LANES-1:0] issue,
    input  logic [NUM_LANES-1:0] issue_valid,
    output logic [NUM_LANES-1:0] issue_ready,
    output exec_t [NUM_LANES-1:0] exec,
    output logic [NUM_LANES-1:0] exec_valid,
    input  logic [NUM_LANES-1:0] exec_ready,
    input  cdb_t [NUM_LANES-1:0] cdb,         // From the functional units
    output commit_t [NUM_LANES-1:0] commit
);

    // Operand lookup, ports 2k and 2k+1 belong to lane k
    operand_addr_t [2*NUM_LANES-1:0]        lookup_addr;
    operand_t [2*NUM_LANES-1:0]             lookup;
    arch_addr_t [2*NUM_LANES-1:0]           file_addr;
    logic [2*NUM_LANES-1:0][DATA_WIDTH-1:0] file_data;

    logic [NUM_LANES-1:0]                   alloc_valid;
    arch_addr_t [NUM_LANES-1:0]             alloc_rd;

    // ========================================================================
    // Reservation stations
    // ========================================================================
    reservation_station #(.LANE_TAG(2'd0)) rs_0 (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue[0]),
        .issue_valid (issue_valid[0]),
        .issue_ready (issue_ready[0]),
        .lookup_addr (lookup_addr[1:0]),
        .lookup      (lookup[1:0]),
        .alloc_valid (alloc_valid[0]),
        .alloc_rd    (alloc_rd[0]),
        .cdb         (cdb),
        .exec        (exec[0]),
        .exec_valid  (exec_valid[0]),
        .exec_ready  (exec_ready[0])
    );

    reservation_station #(.LANE_TAG(2'd1)) rs_1 (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue[1]),
        .issue_valid (issue_valid[1]),
        .issue_ready (issue_ready[1]),
        .lookup_addr (lookup_addr[3:2]),
        .lookup      (lookup[3:2]),
        .alloc_valid (alloc_valid[1]),
        .alloc_rd    (alloc_rd[1]),
        .cdb         (cdb),
        .exec        (exec[1]),
        .exec_valid  (exec_valid[1]),
        .exec_ready  (exec_ready[1])
    );

    reservation_station #(.LANE_TAG(2'd2)) rs_2 (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue[2]),
        .issue_valid (issue_valid[2]),
        .issue_ready (issue_ready[2]),
        .lookup_addr (lookup_addr[5:4]),
        .lookup      (lookup[5:4]),
        .alloc_valid (alloc_valid[2]),
        .alloc_rd    (alloc_rd[2]),
        .cdb         (cdb),
        .exec        (exec[2]),
        .exec_valid  (exec_valid[2]),
        .exec_ready  (exec_ready[2])
    );

    // ========================================================================
    // Pending results and architectural state
    // ========================================================================
    rename_buffer u_rename_buffer (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .cdb         (cdb),
        .lookup_addr (lookup_addr),
        .lookup      (lookup),
        .file_data   (file_data),
        .file_addr   (file_addr),
        .commit      (commit)                // Also the top-level commit ports
    );

    register_file u_register_file (
        .clk         (clk),
        .rst         (rst),
        .rd_addr     (file_addr),
        .rd_data     (file_data),
        .commit      (commit)
    );

endmodule

// ==== source/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station
    import dispatch_pkg::*;
#(
    parameter lane_tag_t LANE_TAG = 2'd0    // Lane and CDB slot of this station
) (
    input  logic                 clk,
    input  logic                 rst,
    input  issue_t               issue,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    output operand_addr_t [1:0]  lookup_addr,  // rs1, rs2
    input  operand_t [1:0]       lookup,
    output logic                 alloc_valid,
    output arch_addr_t           alloc_rd,
    input  cdb_t [NUM_LANES-1:0] cdb,
    output exec_t                exec,
    output logic                 exec_valid,
    input  logic                 exec_ready
);

    logic       full;           // Entry occupied
    logic [3:0] held_op;
    arch_addr_t held_rd;
    operand_t   opnd_a;
    operand_t   opnd_b;

    logic       accept;
    logic       fire;
    operand_t   cap_a;
    operand_t   cap_b;

    // ========================================================================
    // Wakeup
    // ========================================================================
    // Take data from the slot named by the tag
    function automatic operand_t wake(operand_t opnd, cdb_t [NUM_LANES-1:0] bus);
        operand_t res;
        res = opnd;
        if (opnd.tag != TAG_READY) begin
            if (bus[opnd.tag].valid) begin         // Slot k carries only lane k
                res.tag  = TAG_READY;
                res.data = bus[opnd.tag].data;
            end
        end
        return res;
    endfunction

    // ========================================================================
    // Handshakes
    // ========================================================================
    assign exec_valid  = full && opnd_a.tag == TAG_READY && opnd_b.tag == TAG_READY;
    assign fire        = exec_valid && exec_ready;
    assign issue_ready = !full || fire;            // Refill in the issuing cycle
    assign accept      = issue_valid && issue_ready;

    assign lookup_addr[0] = issue.rs1;
    assign lookup_addr[1] = issue.rs2;

    // Allocate only for real destinations
    assign alloc_valid = accept && issue.ctrl.writes_rd && issue.rd != '0;
    assign alloc_rd    = issue.rd;

    always_comb begin
        cap_a = lookup[0];
        if (issue.ctrl.use_imm) begin
            cap_b.tag  = TAG_READY;                 // Immediate is always ready
            cap_b.data = issue.imm;
        end else begin
            cap_b = lookup[1];
        end
    end

    // ========================================================================
    // Entry state
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (fire) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_op <= issue.ctrl.op;
            held_rd <= issue.rd;
            opnd_a  <= wake(cap_a, cdb);            // Same-cycle broadcast counts
            opnd_b  <= wake(cap_b, cdb);
        end else begin
            opnd_a  <= wake(opnd_a, cdb);           // Keeps listening under back-pressure
            opnd_b  <= wake(opnd_b, cdb);
        end
    end

    always_comb begin
        exec.op        = held_op;
        exec.rd        = held_rd;
        exec.operand_a = opnd_a.data;
        exec.operand_b = opnd_b.data;
    end

    // FU may sample exec at any cycle until it takes it
    assert property (@(posedge clk) disable iff (rst)
        exec_valid && !exec_ready |=> exec_valid && $stable(exec))
        else $error("lane %0d exec changed while stalled", LANE_TAG);

endmodule

// ==== source/rename_buffer.sv ====
`timescale 1ns/1ps

module rename_buffer
    import dispatch_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [NUM_LANES-1:0]                   alloc_valid,
    input  arch_addr_t [NUM_LANES-1:0]             alloc_rd,
    input  cdb_t [NUM_LANES-1:0]                   cdb,
    input  operand_addr_t [2*NUM_LANES-1:0]        lookup_addr,
    output operand_t [2*NUM_LANES-1:0]             lookup,
    input  logic [2*NUM_LANES-1:0][DATA_WIDTH-1:0] file_data,
    output arch_addr_t [2*NUM_LANES-1:0]           file_addr,
    output commit_t [NUM_LANES-1:0]                commit
);

    localparam int NUM_PORTS = 2 * NUM_LANES;

    // Entry state, indexed by destination register
    logic [NUM_ARCH_REGS-1:0] entry_busy;
    logic [NUM_ARCH_REGS-1:0] entry_done;                // Result captured
    lane_tag_t                entry_tag  [NUM_ARCH_REGS];
    logic [DATA_WIDTH-1:0]    entry_data [NUM_ARCH_REGS];

    // Per-entry decode of this cycle's events
    logic [NUM_ARCH_REGS-1:0] alloc_hit;
    lane_tag_t                alloc_tag  [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] capture_hit;
    logic [DATA_WIDTH-1:0]    capture_data [NUM_ARCH_REGS];

    // ========================================================================
    // Event decode
    // ========================================================================
    always_comb begin
        alloc_hit = '0;
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            alloc_tag[r] = TAG_READY;
        end
        // Higher lane last, so it wins on same rd
        for (int l = 0; l < NUM_LANES; l++) begin
            if (alloc_valid[l]) begin
                alloc_hit[alloc_rd[l]] = 1'b1;
                alloc_tag[alloc_rd[l]] = lane_tag_t'(l);
            end
        end
    end

    always_comb begin
        capture_hit = '0;
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            capture_data[r] = '0;
        end
        // Only the newest producer of rd may land
        for (int k = 0; k < NUM_LANES; k++) begin
            if (cdb[k].valid && entry_busy[cdb[k].rd] && !entry_done[cdb[k].rd] &&
                entry_tag[cdb[k].rd] == lane_tag_t'(k)) begin
                capture_hit[cdb[k].rd]  = 1'b1;
                capture_data[cdb[k].rd] = cdb[k].data;
            end
        end
    end

    // ========================================================================
    // Entry update
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_busy <= '0;
            entry_done <= '0;
        end else begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                if (alloc_hit[r]) begin                  // Alloc beats capture
                    entry_busy[r] <= 1'b1;
                    entry_done[r] <= 1'b0;
                end else if (capture_hit[r]) begin
                    entry_done[r] <= 1'b1;
                end else if (entry_done[r]) begin        // Committed, free it
                    entry_busy[r] <= 1'b0;
                    entry_done[r] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            if (alloc_hit[r]) begin
                entry_tag[r] <= alloc_tag[r];
            end
            if (capture_hit[r]) begin
                entry_data[r] <= capture_data[r];
            end
        end
    end

    // ========================================================================
    // Operand lookup and commit
    // ========================================================================
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            file_addr[p] = lookup_addr[p].index;
            if (lookup_addr[p].in_buffer && entry_busy[lookup_addr[p].index] &&
                !entry_done[lookup_addr[p].index]) begin
                lookup[p].tag  = entry_tag[lookup_addr[p].index];   // Still waiting
                lookup[p].data = '0;
            end else if (lookup_addr[p].in_buffer && entry_busy[lookup_addr[p].index]) begin
                lookup[p].tag  = TAG_READY;
                lookup[p].data = entry_data[lookup_addr[p].index];  // Done, not yet in file
            end else begin
                lookup[p].tag  = TAG_READY;
                lookup[p].data = file_data[p];
            end
        end
    end

    // A done entry shows on the port of its producing lane
    always_comb begin
        commit = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                if (entry_done[r] && entry_tag[r] == lane_tag_t'(k)) begin
                    commit[k].valid = 1'b1;
                    commit[k].addr  = arch_addr_t'(r);
                    commit[k].data  = entry_data[r];
                end
            end
        end
    end

    for (genvar r = 0; r < NUM_ARCH_REGS; r++) begin : g_free_check
        assert property (@(posedge clk) disable iff (rst)
            entry_done[r] && !alloc_hit[r] |=> !entry_busy[r])
            else $error("rename entry %0d held after commit", r);
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import dispatch_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  arch_addr_t [2*NUM_LANES-1:0]           rd_addr,   // Two per station
    output logic [2*NUM_LANES-1:0][DATA_WIDTH-1:0] rd_data,
    input  commit_t [NUM_LANES-1:0]                commit     // From rename buffer
);

    // x0 has no storage
    logic [DATA_WIDTH-1:0] regs [1:NUM_ARCH_REGS-1];

    // ========================================================================
    // Commit writes
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 1; r < NUM_ARCH_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later port overrides earlier on same address
            for (int p = 0; p < NUM_LANES; p++) begin
                if (commit[p].valid && commit[p].addr != '0) begin
                    regs[commit[p].addr] <= commit[p].data;
                end
            end
        end
    end

    // ========================================================================
    // Combinational reads
    // ========================================================================
    always_comb begin
        for (int p = 0; p < 2*NUM_LANES; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;                       // x0 reads zero
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

    // Stations never allocate x0, so nothing may commit there
    for (genvar p = 0; p < NUM_LANES; p++) begin : g_x0_check
        assert property (@(posedge clk) disable iff (rst)
            commit[p].valid |-> commit[p].addr != '0)
            else $error("commit port %0d targets x0", p);
    end

endmodule

// ==== source/dispatch_pkg.sv ====
package dispatch_pkg;

    // ========================================================================
    // Widths and sizes
    // ========================================================================
    parameter int DATA_WIDTH    = 32;   // Operand and result width
    parameter int NUM_LANES     = 3;
    parameter int NUM_ARCH_REGS = 32;

    typedef logic [4:0] arch_addr_t;    // x0 to x31
    typedef logic [1:0] lane_tag_t;     // Producer lane or ready

    // Tag code for a value that is already present
    parameter lane_tag_t TAG_READY = 2'd3;

    // ========================================================================
    // Shared structs
    // ========================================================================
    typedef struct packed {
        logic       in_buffer;          // Issue stage thinks it is pending
        arch_addr_t index;
    } operand_addr_t;

    typedef struct packed {
        logic       writes_rd;
        logic       use_imm;            // Operand B from immediate
        logic [3:0] op;                 // Opaque here, for the FU
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        operand_addr_t         rs1;
        operand_addr_t         rs2;
        arch_addr_t            rd;
        logic [DATA_WIDTH-1:0] imm;
    } issue_t;

    typedef struct packed {
        lane_tag_t             tag;     // TAG_READY once data is valid
        logic [DATA_WIDTH-1:0] data;
    } operand_t;

    typedef struct packed {
        logic [3:0]            op;
        arch_addr_t            rd;
        logic [DATA_WIDTH-1:0] operand_a;
        logic [DATA_WIDTH-1:0] operand_b;
    } exec_t;

    // One CDB slot, slot k carries lane k
    typedef struct packed {
        logic                  valid;
        arch_addr_t            rd;
        logic [DATA_WIDTH-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        arch_addr_t            addr;
        logic [DATA_WIDTH-1:0] data;
    } commit_t;

endpackage
